// ==== common/lsu_pkg.sv ====
`default_nettype none

package lsu_pkg;

  // byte address as issued by the core
  typedef logic [31:0] addr_t;

  // one memory word, also the width of load and store data
  typedef logic [31:0] word_t;

  // one enable bit per byte lane
  typedef logic [3:0] strb_t;

  // load functions, encoded as funct3
  typedef enum logic [2:0] {
    LD_BS = 3'b000,
    LD_HS = 3'b001,
    LD_W  = 3'b010,
    LD_BU = 3'b100,
    LD_HU = 3'b101
  } load_func_t;

  // store functions, same funct3 encoding
  typedef enum logic [2:0] {
    ST_B = 3'b000,
    ST_H = 3'b001,
    ST_W = 3'b010
  } store_func_t;

  // default depth in words
  localparam int MEM_WORDS_DEF = 1024;

endpackage

`default_nettype wire

// ==== common/axi_lite_if.sv ====
`timescale 1ns/1ps
`default_nettype none

// read address and read data channels
interface axi_rd_if import lsu_pkg::*; ();

  addr_t araddr;
  logic  arvalid;
  logic  arready;

  word_t rdata;
  logic  rvalid;
  logic  rready;

  modport master (
    output araddr, arvalid, rready,
    input  arready, rdata, rvalid
  );

  modport slave (
    input  araddr, arvalid, rready,
    output arready, rdata, rvalid
  );

endinterface

// write address, write data and write response channels
interface axi_wr_if import lsu_pkg::*; ();

  addr_t awaddr;
  logic  awvalid;
  logic  awready;

  word_t wdata;
  strb_t wstrb;
  logic  wvalid;
  logic  wready;

  logic  bvalid;
  logic  bready;

  modport master (
    output awaddr, awvalid, wdata, wstrb, wvalid, bready,
    input  awready, wready, bvalid
  );

  modport slave (
    input  awaddr, awvalid, wdata, wstrb, wvalid, bready,
    output awready, wready, bvalid
  );

endinterface

`default_nettype wire

// ==== lsu/lsu_load_path.sv ====
`timescale 1ns/1ps
`default_nettype none

module lsu_load_path import lsu_pkg::*; (
  input  wire             clk,
  input  wire             rstn,
  input  wire addr_t      raddr,
  input  wire load_func_t rfunc,
  input  wire             rreq_valid,
  output logic            rreq_ready,
  output word_t           rdata,
  output logic            rres_valid,
  input  wire             rres_ready,
  axi_rd_if.master        ram_r
);

  // request parked while the address channel is busy
  addr_t      park_addr;
  load_func_t park_func;

  // function of the beat now on the address channel
  load_func_t ar_func;

  // offset and function of loads between address and data
  logic [1:0] q_off  [2];
  load_func_t q_func [2];
  logic [1:0] q_cnt;

  // returned word parked while the response is stalled
  word_t hold_data;
  word_t shifted;
  word_t formatted;

  logic ar_hs;
  logic ar_free;
  logic req_hs;
  logic issue_new;
  logic park_new;
  logic issue_park;
  logic r_hs;
  logic res_hs;
  logic res_free;
  logic res_load;

  assign ar_hs      = ram_r.arvalid & ram_r.arready;
  assign ar_free    = ~ram_r.arvalid | ram_r.arready;
  assign req_hs     = rreq_valid & rreq_ready;
  assign issue_new  = req_hs & ar_free;
  assign park_new   = req_hs & ~ar_free;
  assign issue_park = ~rreq_ready & ar_free;

  assign r_hs     = ram_r.rvalid & ram_r.rready;
  assign res_hs   = rres_valid & rres_ready;
  assign res_free = ~rres_valid | rres_ready;
  // new response from the bus or from the holding register
  assign res_load = (r_hs | ~ram_r.rready) & res_free;

  always_comb begin
    shifted = ram_r.rdata >> {q_off[0], 3'b000};
    case (q_func[0])
      LD_BS:   formatted = {{24{shifted[7]}}, shifted[7:0]};
      LD_BU:   formatted = {24'b0, shifted[7:0]};
      LD_HS:   formatted = {{16{shifted[15]}}, shifted[15:0]};
      LD_HU:   formatted = {16'b0, shifted[15:0]};
      default: formatted = shifted;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rstn) begin
      rreq_ready    <= 1'b1;
      ram_r.arvalid <= 1'b0;
      ram_r.rready  <= 1'b1;
      rres_valid    <= 1'b0;
      q_cnt         <= '0;
    end else begin
      if (issue_new | issue_park) begin
        ram_r.arvalid <= 1'b1;
      end else if (ar_hs) begin
        ram_r.arvalid <= 1'b0;
      end

      if (park_new) begin
        rreq_ready <= 1'b0;
      end else if (issue_park) begin
        rreq_ready <= 1'b1;
      end

      q_cnt <= q_cnt + 2'(ar_hs) - 2'(r_hs);

      if (r_hs & ~res_free) begin
        ram_r.rready <= 1'b0;
      end else if (~ram_r.rready & res_free) begin
        ram_r.rready <= 1'b1;
      end

      if (res_load) begin
        rres_valid <= 1'b1;
      end else if (res_hs) begin
        rres_valid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (issue_new) begin
      ram_r.araddr <= raddr;
      ar_func      <= rfunc;
    end else if (issue_park) begin
      ram_r.araddr <= park_addr;
      ar_func      <= park_func;
    end

    if (park_new) begin
      park_addr <= raddr;
      park_func <= rfunc;
    end

    // shift on pop first so that a push into slot 0 wins
    if (r_hs) begin
      q_off[0]  <= q_off[1];
      q_func[0] <= q_func[1];
    end
    if (ar_hs) begin
      if (q_cnt == 2'd0 || (r_hs && q_cnt == 2'd1)) begin
        q_off[0]  <= ram_r.araddr[1:0];
        q_func[0] <= ar_func;
      end else begin
        q_off[1]  <= ram_r.araddr[1:0];
        q_func[1] <= ar_func;
      end
    end

    if (r_hs & ~res_free) begin
      hold_data <= formatted;
    end
    if (res_load) begin
      rdata <= ram_r.rready ? formatted : hold_data;
    end
  end

endmodule

`default_nettype wire

// ==== lsu/lsu_store_path.sv ====
`timescale 1ns/1ps
`default_nettype none

module lsu_store_path import lsu_pkg::*; (
  input  wire              clk,
  input  wire              rstn,
  input  wire addr_t       waddr,
  input  wire store_func_t wfunc,
  input  wire word_t       wdata,
  input  wire              wreq_valid,
  output logic             wreq_ready,
  output logic             wres_valid,
  input  wire              wres_ready,
  axi_wr_if.master         ram_w
);

  // beats parked while their channel is busy
  addr_t park_addr;
  word_t park_data;
  strb_t park_strb;
  logic  aw_pend;
  logic  w_pend;

  strb_t base_strb;
  strb_t strb_aligned;
  word_t data_aligned;

  logic req_hs;
  logic aw_hs;
  logic aw_free;
  logic aw_issue_new;
  logic aw_park_new;
  logic aw_issue_park;
  logic w_hs;
  logic w_free;
  logic w_issue_new;
  logic w_park_new;
  logic w_issue_park;
  logic b_hs;
  logic res_hs;

  always_comb begin
    case (wfunc)
      ST_B:    base_strb = 4'b0001;
      ST_H:    base_strb = 4'b0011;
      default: base_strb = 4'b1111;
    endcase
    // lanes follow the byte offset
    data_aligned = wdata << {waddr[1:0], 3'b000};
    strb_aligned = base_strb << waddr[1:0];
  end

  assign req_hs = wreq_valid & wreq_ready;

  assign aw_hs         = ram_w.awvalid & ram_w.awready;
  assign aw_free       = ~ram_w.awvalid | ram_w.awready;
  assign aw_issue_new  = req_hs & aw_free;
  assign aw_park_new   = req_hs & ~aw_free;
  assign aw_issue_park = aw_pend & aw_free;

  assign w_hs         = ram_w.wvalid & ram_w.wready;
  assign w_free       = ~ram_w.wvalid | ram_w.wready;
  assign w_issue_new  = req_hs & w_free;
  assign w_park_new   = req_hs & ~w_free;
  assign w_issue_park = w_pend & w_free;

  assign b_hs   = ram_w.bvalid & ram_w.bready;
  assign res_hs = wres_valid & wres_ready;

  // a response slot frees up when the current one is taken
  assign ram_w.bready = ~wres_valid | wres_ready;

  always_ff @(posedge clk) begin
    if (rstn) begin
      wreq_ready    <= 1'b1;
      ram_w.awvalid <= 1'b0;
      ram_w.wvalid  <= 1'b0;
      aw_pend       <= 1'b0;
      w_pend        <= 1'b0;
      wres_valid    <= 1'b0;
    end else begin
      if (aw_issue_new | aw_issue_park) begin
        ram_w.awvalid <= 1'b1;
      end else if (aw_hs) begin
        ram_w.awvalid <= 1'b0;
      end
      if (w_issue_new | w_issue_park) begin
        ram_w.wvalid <= 1'b1;
      end else if (w_hs) begin
        ram_w.wvalid <= 1'b0;
      end

      if (aw_park_new) begin
        aw_pend <= 1'b1;
      end else if (aw_issue_park) begin
        aw_pend <= 1'b0;
      end
      if (w_park_new) begin
        w_pend <= 1'b1;
      end else if (w_issue_park) begin
        w_pend <= 1'b0;
      end

      // reopen only once both parked beats are out
      if (aw_park_new | w_park_new) begin
        wreq_ready <= 1'b0;
      end else if (~wreq_ready & (~aw_pend | aw_issue_park) & (~w_pend | w_issue_park)) begin
        wreq_ready <= 1'b1;
      end

      if (b_hs) begin
        wres_valid <= 1'b1;
      end else if (res_hs) begin
        wres_valid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (aw_issue_new) begin
      ram_w.awaddr <= waddr;
    end else if (aw_issue_park) begin
      ram_w.awaddr <= park_addr;
    end
    if (w_issue_new) begin
      ram_w.wdata <= data_aligned;
      ram_w.wstrb <= strb_aligned;
    end else if (w_issue_park) begin
      ram_w.wdata <= park_data;
      ram_w.wstrb <= park_strb;
    end

    if (aw_park_new) begin
      park_addr <= waddr;
    end
    if (w_park_new) begin
      park_data <= data_aligned;
      park_strb <= strb_aligned;
    end
  end

endmodule

`default_nettype wire

// ==== logic/sram_axi_slave.sv ====
`timescale 1ns/1ps
`default_nettype none

module sram_axi_slave import lsu_pkg::*; #(
  parameter int MEM_WORDS = MEM_WORDS_DEF
) (
  input  wire     clk,
  input  wire     rstn,
  axi_rd_if.slave rd,
  axi_wr_if.slave wr
);

  localparam int IDX_W = (MEM_WORDS > 1) ? $clog2(MEM_WORDS) : 1;

  typedef logic [IDX_W-1:0] idx_t;

  word_t mem [MEM_WORDS];

  // word address, wrapping at the memory depth
  function automatic idx_t word_index(input addr_t addr);
    return idx_t'(addr[31:2] % MEM_WORDS);
  endfunction

  // read side, address stage then data stage
  logic rd_pend;
  idx_t rd_idx;
  logic rd_adv;
  logic ar_hs;

  // write side, one slot per channel
  logic  aw_full;
  logic  w_full;
  idx_t  wr_idx;
  word_t wr_data;
  strb_t wr_strb;
  logic  aw_hs;
  logic  w_hs;
  logic  do_write;

  // both stages move unless a beat is stuck on rready
  assign rd_adv     = ~rd.rvalid | rd.rready;
  assign rd.arready = rd_adv;
  assign ar_hs      = rd.arvalid & rd.arready;

  assign wr.awready = ~aw_full;
  assign wr.wready  = ~w_full;
  assign aw_hs      = wr.awvalid & wr.awready;
  assign w_hs       = wr.wvalid & wr.wready;
  assign do_write   = aw_full & w_full & (~wr.bvalid | wr.bready);

  always_ff @(posedge clk) begin
    if (rstn) begin
      rd_pend   <= 1'b0;
      rd.rvalid <= 1'b0;
      aw_full   <= 1'b0;
      w_full    <= 1'b0;
      wr.bvalid <= 1'b0;
    end else begin
      if (rd_adv) begin
        rd_pend   <= ar_hs;
        rd.rvalid <= rd_pend;
      end

      if (do_write) begin
        aw_full <= 1'b0;
      end else if (aw_hs) begin
        aw_full <= 1'b1;
      end
      if (do_write) begin
        w_full <= 1'b0;
      end else if (w_hs) begin
        w_full <= 1'b1;
      end

      if (do_write) begin
        wr.bvalid <= 1'b1;
      end else if (wr.bvalid & wr.bready) begin
        wr.bvalid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (ar_hs) begin
      rd_idx <= word_index(rd.araddr);
    end
    if (rd_adv & rd_pend) begin
      rd.rdata <= mem[rd_idx];
    end

    if (aw_hs) begin
      wr_idx <= word_index(wr.awaddr);
    end
    if (w_hs) begin
      wr_data <= wr.wdata;
      wr_strb <= wr.wstrb;
    end

    // byte lanes under the strobe only
    if (do_write) begin
      for (int b = 0; b < 4; b++) begin
        if (wr_strb[b]) begin
          mem[wr_idx][8*b +: 8] <= wr_data[8*b +: 8];
        end
      end
    end
  end

endmodule

`default_nettype wire

// ==== logic/mem_subsys_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_subsys_top import lsu_pkg::*; #(
  parameter int MEM_WORDS = MEM_WORDS_DEF
) (
  input  wire               clk,
  input  wire               rstn,

  // load request and response
  input  wire               rreq_valid,
  output wire               rreq_ready,
  input  wire addr_t        raddr,
  input  wire load_func_t   rfunc,
  output wire               rres_valid,
  input  wire               rres_ready,
  output wire word_t        rdata,

  // store request and response
  input  wire               wreq_valid,
  output wire               wreq_ready,
  input  wire addr_t        waddr,
  input  wire store_func_t  wfunc,
  input  wire word_t        wdata,
  output wire               wres_valid,
  input  wire               wres_ready
);

  axi_rd_if rd_bus ();
  axi_wr_if wr_bus ();

  lsu_load_path u_load (
    .clk        (clk),
    .rstn       (rstn),
    .raddr      (raddr),
    .rfunc      (rfunc),
    .rreq_valid (rreq_valid),
    .rreq_ready (rreq_ready),
    .rdata      (rdata),
    .rres_valid (rres_valid),
    .rres_ready (rres_ready),
    .ram_r      (rd_bus.master)
  );

  lsu_store_path u_store (
    .clk        (clk),
    .rstn       (rstn),
    .waddr      (waddr),
    .wfunc      (wfunc),
    .wdata      (wdata),
    .wreq_valid (wreq_valid),
    .wreq_ready (wreq_ready),
    .wres_valid (wres_valid),
    .wres_ready (wres_ready),
    .ram_w      (wr_bus.master)
  );

  sram_axi_slave #(
    .MEM_WORDS (MEM_WORDS)
  ) u_sram (
    .clk  (clk),
    .rstn (rstn),
    .rd   (rd_bus.slave),
    .wr   (wr_bus.slave)
  );

endmodule

`default_nettype wire

// ==== verif/tb_mem_subsys.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_mem_subsys import lsu_pkg::*; ();

  localparam int MAX_OPS = 64;
  localparam int COLS = 6;
  localparam int TIMEOUT = 200;
  localparam logic [31:0] END_MARK = 32'hffff_ffff;

  logic        clk;
  logic        rstn;
  logic        rreq_valid;
  logic        rreq_ready;
  addr_t       raddr;
  load_func_t  rfunc;
  logic        rres_valid;
  logic        rres_ready;
  word_t       rdata;
  logic        wreq_valid;
  logic        wreq_ready;
  addr_t       waddr;
  store_func_t wfunc;
  word_t       wdata;
  logic        wres_valid;
  logic        wres_ready;

  // columns: test, kind, func, addr, wdata, expect
  logic [31:0] gold [0:MAX_OPS*COLS-1];

  addr_t  exp_addr[$];
  word_t  exp_data[$];
  integer seed = 32'hf2000343;
  logic   stall_on;
  int     stretch;
  logic   timed_out;
  int     test_errs;
  int     passes;
  int     fails;
  int     rres_seen;
  int     wres_seen;

  mem_subsys_top #(
    .MEM_WORDS (MEM_WORDS_DEF)
  ) uut (
    .clk        (clk),
    .rstn       (rstn),
    .rreq_valid (rreq_valid),
    .rreq_ready (rreq_ready),
    .raddr      (raddr),
    .rfunc      (rfunc),
    .rres_valid (rres_valid),
    .rres_ready (rres_ready),
    .rdata      (rdata),
    .wreq_valid (wreq_valid),
    .wreq_ready (wreq_ready),
    .waddr      (waddr),
    .wfunc      (wfunc),
    .wdata      (wdata),
    .wres_valid (wres_valid),
    .wres_ready (wres_ready)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // every response handshake, duplicates included
  always @(posedge clk) begin
    if (rres_valid && rres_ready) begin
      rres_seen++;
    end
    if (wres_valid && wres_ready) begin
      wres_seen++;
    end
  end

  function automatic logic [31:0] field(input int row, input int col);
    return gold[row*COLS+col];
  endfunction

  function automatic load_func_t load_func_of(input int row);
    logic [31:0] v;
    v = field(row, 2);
    return load_func_t'(v[2:0]);
  endfunction

  function automatic store_func_t store_func_of(input int row);
    logic [31:0] v;
    v = field(row, 2);
    return store_func_t'(v[2:0]);
  endfunction

  // low stretches of one to four cycles while stalling
  function automatic logic ready_draw();
    if (!stall_on) begin
      return 1'b1;
    end
    if (stretch > 0) begin
      stretch--;
      return 1'b0;
    end
    if (($random(seed) & 3) == 0) begin
      stretch = $random(seed) & 3;
      return 1'b0;
    end
    return 1'b1;
  endfunction

  task automatic report_hang(input string chan);
    $display("timeout: no handshake on the %s channel within %0d cycles", chan, TIMEOUT);
    timed_out = 1'b1;
  endtask

  task automatic check_word(input addr_t addr, input word_t got, input word_t exp);
    if (got !== exp) begin
      $display("Fail at %0t ns: load from %h returned %h, expected %h", $time, addr, got, exp);
      test_errs++;
    end
  endtask

  task automatic check_wres(input addr_t addr, input logic seen);
    if (!seen) begin
      $display("timeout: store to %h got no write response within %0d cycles", addr, TIMEOUT);
      test_errs++;
      timed_out = 1'b1;
    end
  endtask

  task automatic do_store(input addr_t addr, input store_func_t func, input word_t data);
    int   n;
    logic seen;
    wreq_valid = 1'b1;
    waddr      = addr;
    wfunc      = func;
    wdata      = data;
    n = 0;
    while (!wreq_ready && n < TIMEOUT) begin
      @(negedge clk);
      n++;
    end
    if (!wreq_ready) begin
      report_hang("store request");
      return;
    end
    @(negedge clk);
    wreq_valid = 1'b0;
    seen = 1'b0;
    n = 0;
    while (!seen && n < TIMEOUT) begin
      wres_ready = ready_draw();
      seen = wres_valid && wres_ready;
      @(negedge clk);
      n++;
    end
    check_wres(addr, seen);
  endtask

  // leaves valid high so the next request follows back to back
  task automatic issue_load(input addr_t addr, input load_func_t func);
    int n;
    rreq_valid = 1'b1;
    raddr      = addr;
    rfunc      = func;
    n = 0;
    while (!rreq_ready && n < TIMEOUT) begin
      @(negedge clk);
      n++;
    end
    if (!rreq_ready) begin
      report_hang("load request");
      return;
    end
    @(negedge clk);
  endtask

  task automatic collect_loads(input int count);
    int n;
    int got_cnt;
    n = 0;
    got_cnt = 0;
    while (got_cnt < count && n < TIMEOUT && !timed_out) begin
      rres_ready = ready_draw();
      if (rres_valid && rres_ready) begin
        check_word(exp_addr[got_cnt], rdata, exp_data[got_cnt]);
        got_cnt++;
        n = 0;
      end
      @(negedge clk);
      n++;
    end
    if (got_cnt < count && !timed_out) begin
      report_hang("load response");
    end
  endtask

  task automatic finish_test(input int id, input int loads, input int stores,
                             input int r_base, input int w_base);
    // idle with ready high so that a stray response gets counted
    rres_ready = 1'b1;
    wres_ready = 1'b1;
    repeat (4) @(negedge clk);
    if (rres_seen - r_base != loads || wres_seen - w_base != stores) begin
      $display("test %0d: %0d load and %0d write responses for %0d loads and %0d stores",
               id, rres_seen - r_base, wres_seen - w_base, loads, stores);
      test_errs++;
    end
    if (test_errs == 0 && !timed_out) begin
      passes++;
      $display("test %0d passed", id);
    end else begin
      fails++;
      $display("test %0d failed with %0d errors", id, test_errs);
    end
  endtask

  initial begin
    int i;
    int k;
    int g_start;
    int cur_test;
    int t_loads;
    int t_stores;
    int r_base;
    int w_base;
    for (i = 0; i < MAX_OPS * COLS; i++) begin
      gold[i] = END_MARK;
    end
    $readmemh("verif/mem_subsys_golden.txt", gold);
    rstn       = 1'b1;
    rreq_valid = 1'b0;
    raddr      = '0;
    rfunc      = LD_W;
    rres_ready = 1'b1;
    wreq_valid = 1'b0;
    waddr      = '0;
    wfunc      = ST_W;
    wdata      = '0;
    wres_ready = 1'b1;
    stall_on   = 1'b0;
    stretch    = 0;
    timed_out  = 1'b0;
    test_errs  = 0;
    passes     = 0;
    fails      = 0;
    rres_seen  = 0;
    wres_seen  = 0;
    repeat (8) @(posedge clk);
    @(negedge clk);
    rstn = 1'b0;
    @(negedge clk);

    i = 0;
    while (field(i, 0) != END_MARK && !timed_out) begin
      cur_test  = field(i, 0);
      test_errs = 0;
      t_loads   = 0;
      t_stores  = 0;
      r_base    = rres_seen;
      w_base    = wres_seen;
      // test 5 runs with random response back-pressure
      stall_on  = (cur_test == 5);
      stretch   = 0;
      while (field(i, 0) == cur_test && !timed_out) begin
        if (field(i, 1) == 0) begin
          do_store(field(i, 3), store_func_of(i), field(i, 4));
          t_stores++;
          i++;
        end else begin
          // kind 2 rows form one group issued without waiting
          g_start = i;
          exp_addr.delete();
          exp_data.delete();
          do begin
            exp_addr.push_back(field(i, 3));
            exp_data.push_back(field(i, 5));
            i++;
          end while (field(g_start, 1) == 2 && field(i, 1) == 2 && field(i, 0) == cur_test);
          t_loads += exp_addr.size();
          fork
            begin
              for (k = g_start; k < i && !timed_out; k++) begin
                issue_load(field(k, 3), load_func_of(k));
              end
              rreq_valid = 1'b0;
            end
            collect_loads(exp_addr.size());
          join
        end
      end
      finish_test(cur_test, t_loads, t_stores, r_base, w_base);
    end

    $display("tests passed %0d, failed %0d", passes, fails);
    if (fails == 0 && passes > 0 && !timed_out) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== verif/mem_subsys_golden.txt ====
// columns in hex: test kind func addr wdata expect
// kind 0 store, 1 load on its own, 2 loads issued back to back; func is funct3
// word round trip, 0x1000 wraps to word 0
1 0 2 00000000 11223344 00000000
1 0 2 00000004 a5a5f00f 00000000
1 0 2 00000010 deadbeef 00000000
1 0 2 00000ffc 0badcafe 00000000
1 1 2 00000000 00000000 11223344
1 1 2 00000004 00000000 a5a5f00f
1 1 2 00000010 00000000 deadbeef
1 1 2 00000ffc 00000000 0badcafe
1 1 2 00001000 00000000 11223344
// strobe merging, upper wdata bits must not leak
2 0 2 00000020 ffffffff 00000000
2 0 0 00000020 123456aa 00000000
2 0 0 00000021 9abcdebb 00000000
2 0 0 00000022 00000011 00000000
2 0 0 00000023 fedcba22 00000000
2 1 2 00000020 00000000 2211bbaa
2 0 2 00000024 00000000 00000000
2 0 1 00000024 ffff1234 00000000
2 0 1 00000026 5555abcd 00000000
2 1 2 00000024 00000000 abcd1234
// load extension
3 0 2 00000030 08f17f85 00000000
3 0 2 00000034 5a3cc0de 00000000
3 1 0 00000030 00000000 ffffff85
3 1 4 00000030 00000000 00000085
3 1 0 00000031 00000000 0000007f
3 1 4 00000032 00000000 000000f1
3 1 0 00000032 00000000 fffffff1
3 1 0 00000033 00000000 00000008
3 1 1 00000030 00000000 00007f85
3 1 5 00000032 00000000 000008f1
3 1 1 00000034 00000000 ffffc0de
3 1 5 00000034 00000000 0000c0de
3 1 1 00000036 00000000 00005a3c
// pipelined loads
4 2 2 00000000 00000000 11223344
4 2 0 00000033 00000000 00000008
4 2 5 00000034 00000000 0000c0de
4 2 4 00000022 00000000 00000011
4 2 1 00000026 00000000 ffffabcd
4 2 2 00000ffc 00000000 0badcafe
// back-pressure on both responses
5 0 2 00000040 c3c3c3c3 00000000
5 0 1 00000042 00007e01 00000000
5 0 0 00000041 000000aa 00000000
5 2 2 00000040 00000000 7e01aac3
5 2 0 00000041 00000000 ffffffaa
5 2 5 00000042 00000000 00007e01
5 2 4 00000040 00000000 000000c3
5 2 2 00000010 00000000 deadbeef

// ==== mem_subsys.f ====
common/lsu_pkg.sv
common/axi_lite_if.sv
lsu/lsu_load_path.sv
lsu/lsu_store_path.sv
logic/sram_axi_slave.sv
logic/mem_subsys_top.sv
verif/tb_mem_subsys.sv
